/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pulp_soc \
	  -f pulp_soc.f -Mdir obj_dir -o sim_pulp_soc

run: compile
	@out="$$(./obj_dir/sim_pulp_soc)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

/* bench/clk_gen.sv */
/*
 * clk_gen
 * 20 ns testbench clock and a reset held low for the first 10 cycles.
 */
module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release between edges so the first active edge is clean
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* bench/pulp_soc_assert.sv */
/*
 * pulp_soc_assert
 * Response stability, reset state and error bit checks on the host port.
 */
module pulp_soc_assert import soc_pkg::*; (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              req_valid_i,
  input logic              req_ready_o,
  input logic [ADDR_W-1:0] addr_i,
  input logic              resp_valid_o,
  input logic              resp_ready_i,
  input logic [DATA_W-1:0] rdata_o,
  input logic              error_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic       mapped;
  logic [7:0] mapped_q;
  logic [2:0] wr_ptr_q;
  logic [2:0] rd_ptr_q;

  // both regions are aligned to their size
  assign mapped =
    (addr_i[ADDR_W-1:$clog2(L2_BYTES)] == L2_BASE[ADDR_W-1:$clog2(L2_BYTES)]) ||
    (addr_i[ADDR_W-1:$clog2(PERIPH_BYTES)] == PERIPH_BASE[ADDR_W-1:$clog2(PERIPH_BYTES)]);

  // shadow order of mapped and unmapped requests
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        mapped_q[wr_ptr_q] <= mapped;
        wr_ptr_q           <= wr_ptr_q + 3'd1;
      end
      if (resp_valid_o && resp_ready_i) begin
        rd_ptr_q <= rd_ptr_q + 3'd1;
      end
    end
  end

  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable({rdata_o, error_o}))
    else $error("response changed or vanished while held back");

  reset_idle_a: assert property (@(posedge clk_i) !rst_n_i |=> !resp_valid_o)
    else $error("response pending right after reset");

  mapped_no_error_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && mapped_q[rd_ptr_q] |-> !error_o)
    else $error("error bit set for a mapped address");

endmodule

/* bench/tb_pulp_soc.sv */
/*
 * tb_pulp_soc
 * Random host traffic into pulp_soc, checked in order against a model
 * of the L2 memory and the peripheral registers.
 */
module tb_pulp_soc import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  logic                req_ready;
  logic                write;
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] strb;
  logic                resp_valid;
  logic                resp_ready;
  logic [DATA_W-1:0]   rdata;
  logic                error;

  logic [31:0]         lfsr_q;
  logic [31:0]         ready_lfsr_q;
  // sparse L2 image, only written words are ever read back
  logic [DATA_W-1:0]   l2_img [int unsigned];
  logic [31:0]         periph_regs [16];
  logic [DATA_W-1:0]   exp_data_q [$];
  logic                exp_err_q [$];
  logic [ADDR_W-1:0]   exp_addr_q [$];
  int unsigned         l2_words [16];
  bit                  hold_resp;
  bit                  stall_ok;
  bit                  stalled;
  bit                  timed_out;
  int                  check_cnt;
  int                  err_cnt;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pulp_soc #(
    .MAX_OUTSTANDING (4),
    .L2_WORDS        (256)
  ) u_pulp_soc (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .write_i      (write),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .strb_i       (strb),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .rdata_o      (rdata),
    .error_o      (error)
  );

  bind pulp_soc pulp_soc_assert u_pulp_soc_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .addr_i       (addr_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .rdata_o      (rdata_o),
    .error_o      (error_o)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per returned bit
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i] = lfsr_q[0];
    end
    return v;
  endfunction

  function automatic logic [ADDR_W-1:0] unmapped_addr();
    logic [ADDR_W-1:0] a;
    a = ADDR_W'(rand_bits(32));
    // move away from both mapped regions
    if (a[31:24] == 8'h1C || a[31:24] == 8'h1A) begin
      a[31] = 1'b1;
    end
    return a;
  endfunction

  // after a timeout the remaining traffic is skipped
  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
    err_cnt++;
  endtask

  task automatic wait_accept(input int limit, output bit accepted);
    int n;
    n = 0;
    accepted = 1'b0;
    while (!accepted && n < limit) begin
      @(posedge clk);
      accepted = req_ready;
      n++;
    end
  endtask

  task automatic send(input logic wr, input logic [ADDR_W-1:0] a,
                      input logic [DATA_W-1:0] d, input logic [DATA_W/8-1:0] s,
                      input logic [DATA_W-1:0] exp_d, input logic exp_e);
    bit ok;
    if (timed_out) begin
      return;
    end
    @(negedge clk);
    req_valid = 1'b1;
    write     = wr;
    addr      = a;
    wdata     = d;
    strb      = s;
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    exp_addr_q.push_back(a);
    wait_accept(stall_ok ? 20 : 200, ok);
    if (!ok) begin
      if (stall_ok) begin
        stalled = 1'b1;
      end else begin
        report_timeout("request was not accepted within 200 cycles");
      end
    end
  endtask

  task automatic idle_host();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic l2_access(input logic wr, input int unsigned word,
                           input logic [DATA_W-1:0] d, input logic [DATA_W/8-1:0] s);
    logic [DATA_W-1:0] cur;
    logic [DATA_W-1:0] exp_d;
    cur   = l2_img.exists(word) ? l2_img[word] : '0;
    exp_d = '0;
    if (wr) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (s[b]) begin
          cur[b*8 +: 8] = d[b*8 +: 8];
        end
      end
      l2_img[word] = cur;
    end else begin
      exp_d = cur;
    end
    send(wr, L2_BASE + ADDR_W'(word * 16), d, s, exp_d, 1'b0);
  endtask

  // one wide slot covers four registers, one per 32-bit lane
  task automatic periph_access(input logic wr, input int unsigned slot,
                               input logic [DATA_W-1:0] d, input logic [DATA_W/8-1:0] s);
    logic [DATA_W-1:0] exp_d;
    int unsigned       r;
    exp_d = '0;
    for (int l = 0; l < 4; l++) begin
      r = slot * 4 + l;
      if (s[l*4 +: 4] != 4'h0) begin
        if (wr && r != 0) begin
          for (int b = 0; b < 4; b++) begin
            if (s[l*4 + b]) begin
              periph_regs[r][b*8 +: 8] = d[l*32 + b*8 +: 8];
            end
          end
        end else if (!wr) begin
          exp_d[l*32 +: 32] = (r == 0) ? SOC_ID : periph_regs[r];
        end
      end
    end
    send(wr, PERIPH_BASE + ADDR_W'(slot * 16), d, s, exp_d, 1'b0);
  endtask

  task automatic err_access(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [DATA_W/8-1:0] s);
    send(wr, a, d, s, '0, 1'b1);
  endtask

  task automatic random_request();
    int unsigned         kind;
    int unsigned         pick;
    logic                wr;
    logic [DATA_W-1:0]   d;
    logic [DATA_W/8-1:0] s;
    kind = 32'(rand_bits(2));
    pick = 32'(rand_bits(4));
    wr   = 1'(rand_bits(1));
    d    = rand_bits(128);
    s    = 16'(rand_bits(16));
    case (kind)
      0, 3:    l2_access(wr, l2_words[pick], d, s);
      1:       periph_access(wr, pick % 4, d, s);
      default: err_access(wr, unmapped_addr(), d, s);
    endcase
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (!timed_out && exp_data_q.size() != 0 && n < 1000) begin
      @(posedge clk);
      n++;
    end
    if (!timed_out && exp_data_q.size() != 0) begin
      report_timeout("responses still outstanding after 1000 cycles");
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d (%s) finished, %0d checks and %0d failures so far",
             num, name, check_cnt, err_cnt);
  endtask

  // random back-pressure, ready about three cycles in four
  always @(negedge clk) begin
    if (rst_n !== 1'b1 || hold_resp) begin
      resp_ready = 1'b0;
    end else begin
      ready_lfsr_q = lfsr_next(ready_lfsr_q);
      resp_ready   = ready_lfsr_q[0];
      ready_lfsr_q = lfsr_next(ready_lfsr_q);
      resp_ready   = resp_ready | ready_lfsr_q[0];
    end
  end

  // in-order response checker
  always @(posedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      assert (exp_data_q.size() != 0) else begin
        $display("unexpected response at %0t ns with no request outstanding", $time);
        err_cnt++;
      end
      if (exp_data_q.size() != 0) begin
        check_cnt++;
        assert (rdata === exp_data_q[0] && error === exp_err_q[0]) else begin
          $display("error at %0t ns: addr %h got rdata %h error %b, expected %h %b",
                   $time, exp_addr_q[0], rdata, error, exp_data_q[0], exp_err_q[0]);
          err_cnt++;
        end
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_addr_q.pop_front());
      end
    end
  end

  initial begin
    int                  n;
    int unsigned         slot;
    logic [ADDR_W-1:0]   a;
    logic [DATA_W-1:0]   d;
    logic [DATA_W/8-1:0] s;
    bit                  ok;
    req_valid    = 1'b0;
    write        = 1'b0;
    addr         = '0;
    wdata        = '0;
    strb         = '0;
    resp_ready   = 1'b0;
    hold_resp    = 1'b0;
    stall_ok     = 1'b0;
    stalled      = 1'b0;
    timed_out    = 1'b0;
    check_cnt    = 0;
    err_cnt      = 0;
    lfsr_q       = 32'h1bef;
    ready_lfsr_q = 32'h1bef;
    for (int r = 0; r < 16; r++) begin
      periph_regs[r] = '0;
    end

    n = 0;
    while (rst_n !== 1'b1 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      report_timeout("reset was not released within 50 cycles");
    end

    // full writes first so every byte of a used word is known
    for (int i = 0; i < 16; i++) begin
      l2_words[i] = 32'(rand_bits(8));
      d = rand_bits(128);
      l2_access(1'b1, l2_words[i], d, '1);
    end
    for (int i = 0; i < 32; i++) begin
      slot = 32'(rand_bits(4));
      d    = rand_bits(128);
      s    = 16'(rand_bits(16));
      l2_access(1'b1, l2_words[slot], d, s);
    end
    for (int i = 0; i < 16; i++) begin
      l2_access(1'b0, l2_words[i], '0, '1);
    end
    idle_host();
    wait_drain();
    report_test(1, "L2 strobed write and read");

    for (int i = 0; i < 12; i++) begin
      slot = 32'(rand_bits(2));
      d    = rand_bits(128);
      s    = 16'(rand_bits(16));
      periph_access(1'b1, slot, d, s);
      slot = 32'(rand_bits(2));
      s    = 16'(rand_bits(16));
      periph_access(1'b0, slot, '0, s);
    end
    // register 0 keeps the ID after a write
    d = rand_bits(128);
    periph_access(1'b1, 0, d, '1);
    for (int k = 0; k < 4; k++) begin
      periph_access(1'b0, k, '0, '1);
    end
    // no lane selected at all
    periph_access(1'b0, 1, '0, '0);
    idle_host();
    wait_drain();
    report_test(2, "peripheral access through the downsizer");

    // unmapped writes share their low address bits with the L2 words in use
    for (int i = 0; i < 16; i++) begin
      a       = unmapped_addr();
      a[11:0] = 12'(l2_words[i] * 16);
      d       = rand_bits(128);
      err_access(1'b1, a, d, '1);
    end
    for (int i = 0; i < 4; i++) begin
      err_access(1'b0, unmapped_addr(), '0, '1);
    end
    for (int i = 0; i < 16; i++) begin
      l2_access(1'b0, l2_words[i], '0, '1);
    end
    for (int k = 0; k < 4; k++) begin
      periph_access(1'b0, k, '0, '1);
    end
    idle_host();
    wait_drain();
    report_test(3, "decode errors");

    for (int i = 0; i < 40; i++) begin
      random_request();
    end
    idle_host();
    wait_drain();
    report_test(4, "interleaved ordering");

    // hold responses until the host port stalls
    hold_resp = 1'b1;
    stall_ok  = 1'b1;
    for (int i = 0; i < 16 && !stalled; i++) begin
      random_request();
    end
    assert (stalled) else begin
      $display("req_ready_o never fell while responses were held back");
      err_cnt++;
    end
    hold_resp = 1'b0;
    stall_ok  = 1'b0;
    if (stalled) begin
      wait_accept(200, ok);
      if (!ok) begin
        report_timeout("stalled request was not accepted after release");
      end
    end
    idle_host();
    wait_drain();
    report_test(5, "back-pressure");

    $display("5 tests, %0d checks, %0d failures", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* pulp_soc.f */
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/stream_fifo.sv
verilog/soc_bus.sv
verilog/dw_downsizer.sv
verilog/l2_mem.sv
verilog/soc_periph.sv
verilog/pulp_soc.sv
bench/clk_gen.sv
bench/pulp_soc_assert.sv
bench/tb_pulp_soc.sv

/* verilog/dw_downsizer.sv */
/*
 * dw_downsizer
 * Splits a 128-bit access into 32-bit accesses, one per selected lane,
 * and gathers the narrow read data back into one wide response.
 */
module dw_downsizer import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  mem_bus_if.slv                 wide_i,
  // narrow side
  output logic                   n_req_valid_o,
  input  logic                   n_req_ready_i,
  output logic                   n_write_o,
  output logic [ADDR_W-1:0]      n_addr_o,
  output logic [PERIPH_DW-1:0]   n_wdata_o,
  output logic [PERIPH_DW/8-1:0] n_strb_o,
  input  logic                   n_resp_valid_i,
  output logic                   n_resp_ready_o,
  input  logic [PERIPH_DW-1:0]   n_rdata_i,
  input  logic                   n_error_i
);

  localparam int unsigned N_LANES = DATA_W / PERIPH_DW;
  localparam int unsigned LANE_B  = PERIPH_DW / 8;

  typedef logic [$clog2(N_LANES)-1:0] lane_t;

  logic                busy_q;
  logic                resp_q;
  logic [N_LANES-1:0]  issue_q;
  logic                write_q;
  logic [ADDR_W-1:0]   addr_q;
  logic [DATA_W-1:0]   wdata_q;
  logic [DATA_W/8-1:0] strb_q;
  logic [DATA_W-1:0]   rdata_q;
  logic                err_q;

  logic [N_LANES-1:0]  lane_sel;
  lane_t               cur_lane;
  lane_t               resp_lane;
  logic                lane_push_ready;
  logic                lane_pend;
  logic                wide_acc;
  logic                n_req_acc;
  logic                n_resp_acc;

  // a lane counts as selected if any of its strobes is set
  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      lane_sel[i] = |wide_i.strb[i*LANE_B +: LANE_B];
    end
  end

  // lowest lane still to be issued
  always_comb begin
    cur_lane = '0;
    for (int i = N_LANES-1; i >= 0; i--) begin
      if (issue_q[i]) begin
        cur_lane = lane_t'(i);
      end
    end
  end

  assign wide_i.req_ready  = ~busy_q & ~resp_q;
  assign wide_i.resp_valid = resp_q;
  assign wide_i.rdata      = rdata_q;
  assign wide_i.error      = err_q;

  assign wide_acc   = wide_i.req_valid & wide_i.req_ready;
  assign n_req_acc  = n_req_valid_o & n_req_ready_i;
  assign n_resp_acc = n_resp_valid_i & n_resp_ready_o;

  assign n_req_valid_o  = busy_q & (|issue_q) & lane_push_ready;
  assign n_write_o      = write_q;
  assign n_addr_o       = {addr_q[ADDR_W-1:4], 4'b0000} +
                          {{(ADDR_W-4){1'b0}}, cur_lane, 2'b00};
  assign n_wdata_o      = wdata_q[cur_lane*PERIPH_DW +: PERIPH_DW];
  assign n_strb_o       = strb_q[cur_lane*LANE_B +: LANE_B];
  assign n_resp_ready_o = lane_pend;

  // lane of every narrow access in flight
  stream_fifo #(
    .payload_t (lane_t),
    .DEPTH     (4)
  ) i_lane_fifo (
    .clk_i,
    .rst_n_i,
    .push_valid_i (n_req_acc),
    .push_data_i  (cur_lane),
    .push_ready_o (lane_push_ready),
    .pop_valid_o  (lane_pend),
    .pop_data_o   (resp_lane),
    .pop_ready_i  (n_resp_valid_i)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      resp_q  <= 1'b0;
      issue_q <= '0;
    end else if (wide_acc) begin
      issue_q <= lane_sel;
      busy_q  <= |lane_sel;
      // nothing selected, answer right away
      resp_q  <= ~|lane_sel;
    end else if (busy_q) begin
      if (n_req_acc) begin
        issue_q[cur_lane] <= 1'b0;
      end
      if (issue_q == '0 && !lane_pend) begin
        busy_q <= 1'b0;
        resp_q <= 1'b1;
      end
    end else if (resp_q && wide_i.resp_ready) begin
      resp_q <= 1'b0;
    end
  end

  // request payload and collected response
  always_ff @(posedge clk_i) begin
    if (wide_acc) begin
      write_q <= wide_i.write;
      addr_q  <= wide_i.addr;
      wdata_q <= wide_i.wdata;
      strb_q  <= wide_i.strb;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (n_resp_acc) begin
      rdata_q[resp_lane*PERIPH_DW +: PERIPH_DW] <= n_rdata_i;
      err_q <= err_q | n_error_i;
    end
  end

endmodule

/* verilog/l2_mem.sv */
/*
 * l2_mem
 * 128-bit L2 memory with byte strobes, answering one cycle after a request.
 */
module l2_mem import soc_pkg::*; #(
  parameter int unsigned L2_WORDS = L2_BYTES / (DATA_W/8)
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_bus_if.slv bus_i
);

  localparam int unsigned OFF_W = $clog2(DATA_W/8);
  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  logic [DATA_W-1:0] mem_q [L2_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              req_acc;
  logic              resp_valid_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx     = bus_i.addr[OFF_W +: IDX_W];
  // ready while the response slot is free or draining
  assign bus_i.req_ready = ~resp_valid_q | bus_i.resp_ready;
  assign req_acc = bus_i.req_valid & bus_i.req_ready;

  always_ff @(posedge clk_i) begin
    if (req_acc && bus_i.write) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (bus_i.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_acc) begin
      rdata_q <= bus_i.write ? '0 : mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_acc) begin
      resp_valid_q <= 1'b1;
    end else if (bus_i.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign bus_i.resp_valid = resp_valid_q;
  assign bus_i.rdata      = rdata_q;
  assign bus_i.error      = 1'b0;

endmodule

/* verilog/mem_bus_if.sv */
/*
 * mem_bus_if
 * Request/response bus with valid/ready handshakes on both channels.
 */
interface mem_bus_if import soc_pkg::*; #(
  parameter int unsigned DW = DATA_W
) ();

  // request channel
  logic              req_valid;
  logic              req_ready;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DW-1:0]     wdata;
  logic [DW/8-1:0]   strb;

  // response channel
  logic              resp_valid;
  logic              resp_ready;
  logic [DW-1:0]     rdata;
  logic              error;

  modport mst (
    output req_valid, write, addr, wdata, strb, resp_ready,
    input  req_ready, resp_valid, rdata, error
  );

  modport slv (
    input  req_valid, write, addr, wdata, strb, resp_ready,
    output req_ready, resp_valid, rdata, error
  );

endinterface

/* verilog/pulp_soc.sv */
/*
 * pulp_soc
 * SoC top level: host port, SoC bus, L2 memory and the peripheral
 * registers behind a width downsizer.
 */
module pulp_soc import soc_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 4,
  parameter int unsigned L2_WORDS        = L2_BYTES / (DATA_W/8)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                write_i,
  input  logic [ADDR_W-1:0]   addr_i,
  input  logic [DATA_W-1:0]   wdata_i,
  input  logic [DATA_W/8-1:0] strb_i,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                error_o
);

  // soc bus to L2 and to the downsizer
  mem_bus_if #(.DW(DATA_W)) l2_bus ();
  mem_bus_if #(.DW(DATA_W)) periph_wide ();

  // downsizer to peripherals
  logic                   n_req_valid;
  logic                   n_req_ready;
  logic                   n_write;
  logic [ADDR_W-1:0]      n_addr;
  logic [PERIPH_DW-1:0]   n_wdata;
  logic [PERIPH_DW/8-1:0] n_strb;
  logic                   n_resp_valid;
  logic                   n_resp_ready;
  logic [PERIPH_DW-1:0]   n_rdata;
  logic                   n_error;

  soc_bus #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .req_valid_i,
    .req_ready_o,
    .write_i,
    .addr_i,
    .wdata_i,
    .strb_i,
    .resp_valid_o,
    .resp_ready_i,
    .rdata_o,
    .error_o,
    .l2_o         (l2_bus),
    .periph_o     (periph_wide)
  );

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk_i,
    .rst_n_i,
    .bus_i    (l2_bus)
  );

  dw_downsizer i_dwc_periph (
    .clk_i,
    .rst_n_i,
    .wide_i         (periph_wide),
    .n_req_valid_o  (n_req_valid),
    .n_req_ready_i  (n_req_ready),
    .n_write_o      (n_write),
    .n_addr_o       (n_addr),
    .n_wdata_o      (n_wdata),
    .n_strb_o       (n_strb),
    .n_resp_valid_i (n_resp_valid),
    .n_resp_ready_o (n_resp_ready),
    .n_rdata_i      (n_rdata),
    .n_error_i      (n_error)
  );

  soc_periph i_periphs (
    .clk_i,
    .rst_n_i,
    .n_req_valid_i  (n_req_valid),
    .n_req_ready_o  (n_req_ready),
    .n_write_i      (n_write),
    .n_addr_i       (n_addr),
    .n_wdata_i      (n_wdata),
    .n_strb_i       (n_strb),
    .n_resp_valid_o (n_resp_valid),
    .n_resp_ready_i (n_resp_ready),
    .n_rdata_o      (n_rdata),
    .n_error_o      (n_error)
  );

endmodule

/* verilog/soc_bus.sv */
/*
 * soc_bus
 * Decodes host requests onto L2 or the peripherals, answers unmapped
 * addresses with an error and returns all responses in request order.
 */
module soc_bus import soc_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // host port
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              write_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [DATA_W/8-1:0] strb_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              error_o,
  // targets
  mem_bus_if.mst            l2_o,
  mem_bus_if.mst            periph_o
);

  tgt_e req_tgt;
  logic tgt_ready;
  logic ord_push_ready;
  logic ord_valid;
  tgt_e ord_head;
  logic err_pend_q;

  // address decode
  always_comb begin
    if ((addr_i - L2_BASE) < ADDR_W'(L2_BYTES)) begin
      req_tgt = TGT_L2;
    end else if ((addr_i - PERIPH_BASE) < ADDR_W'(PERIPH_BYTES)) begin
      req_tgt = TGT_PERIPH;
    end else begin
      req_tgt = TGT_ERR;
    end
  end

  always_comb begin
    case (req_tgt)
      TGT_L2:     tgt_ready = l2_o.req_ready;
      TGT_PERIPH: tgt_ready = periph_o.req_ready;
      default:    tgt_ready = 1'b1;
    endcase
  end

  assign req_ready_o = ord_push_ready & tgt_ready;

  // request goes out unregistered, both targets see the same payload
  assign l2_o.req_valid     = req_valid_i & ord_push_ready & (req_tgt == TGT_L2);
  assign l2_o.write         = write_i;
  assign l2_o.addr          = addr_i;
  assign l2_o.wdata         = wdata_i;
  assign l2_o.strb          = strb_i;
  assign periph_o.req_valid = req_valid_i & ord_push_ready & (req_tgt == TGT_PERIPH);
  assign periph_o.write     = write_i;
  assign periph_o.addr      = addr_i;
  assign periph_o.wdata     = wdata_i;
  assign periph_o.strb      = strb_i;

  // target order of accepted requests
  stream_fifo #(
    .payload_t (tgt_e),
    .DEPTH     (MAX_OUTSTANDING)
  ) i_order_fifo (
    .clk_i,
    .rst_n_i,
    .push_valid_i (req_valid_i & tgt_ready),
    .push_data_i  (req_tgt),
    .push_ready_o (ord_push_ready),
    .pop_valid_o  (ord_valid),
    .pop_data_o   (ord_head),
    .pop_ready_i  (resp_valid_o & resp_ready_i)
  );

  // error response, raised one cycle after an ERR entry reaches the head
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_pend_q <= 1'b0;
    end else if (err_pend_q) begin
      if (resp_ready_i) begin
        err_pend_q <= 1'b0;
      end
    end else if (ord_valid && ord_head == TGT_ERR) begin
      err_pend_q <= 1'b1;
    end
  end

  // response merge follows the FIFO head
  always_comb begin
    case (ord_head)
      TGT_L2: begin
        resp_valid_o = ord_valid & l2_o.resp_valid;
        rdata_o      = l2_o.rdata;
        error_o      = l2_o.error;
      end
      TGT_PERIPH: begin
        resp_valid_o = ord_valid & periph_o.resp_valid;
        rdata_o      = periph_o.rdata;
        error_o      = periph_o.error;
      end
      default: begin
        resp_valid_o = ord_valid & err_pend_q;
        rdata_o      = '0;
        error_o      = 1'b1;
      end
    endcase
  end

  assign l2_o.resp_ready     = resp_ready_i & ord_valid & (ord_head == TGT_L2);
  assign periph_o.resp_ready = resp_ready_i & ord_valid & (ord_head == TGT_PERIPH);

endmodule

/* verilog/soc_periph.sv */
/*
 * soc_periph
 * Sixteen 32-bit registers, register 0 holding the read-only SoC ID.
 */
module soc_periph import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   n_req_valid_i,
  output logic                   n_req_ready_o,
  input  logic                   n_write_i,
  input  logic [ADDR_W-1:0]      n_addr_i,
  input  logic [PERIPH_DW-1:0]   n_wdata_i,
  input  logic [PERIPH_DW/8-1:0] n_strb_i,
  output logic                   n_resp_valid_o,
  input  logic                   n_resp_ready_i,
  output logic [PERIPH_DW-1:0]   n_rdata_o,
  output logic                   n_error_o
);

  logic [PERIPH_DW-1:0] regs_q [16];
  logic [3:0]           idx;
  logic                 req_acc;
  logic                 resp_valid_q;
  logic [PERIPH_DW-1:0] rdata_q;

  assign idx           = n_addr_i[5:2];
  assign n_req_ready_o = ~resp_valid_q | n_resp_ready_i;
  assign req_acc       = n_req_valid_i & n_req_ready_o;

  // register 0 never takes writes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < 16; r++) begin
        regs_q[r] <= '0;
      end
    end else if (req_acc && n_write_i && idx != 4'd0) begin
      for (int b = 0; b < PERIPH_DW/8; b++) begin
        if (n_strb_i[b]) begin
          regs_q[idx][b*8 +: 8] <= n_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_acc) begin
      if (n_write_i) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= (idx == 4'd0) ? SOC_ID : regs_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_acc) begin
      resp_valid_q <= 1'b1;
    end else if (n_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign n_resp_valid_o = resp_valid_q;
  assign n_rdata_o      = rdata_q;
  assign n_error_o      = 1'b0;

endmodule

/* verilog/soc_pkg.sv */
/*
 * soc_pkg
 * Widths, address map, routing targets and the peripheral ID of the SoC.
 */
package soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 128;
  localparam int unsigned PERIPH_DW = 32;

  // L2 region, 256 words of 16 bytes
  localparam logic [ADDR_W-1:0] L2_BASE  = 32'h1C00_0000;
  localparam int unsigned       L2_BYTES = 4096;

  // peripheral region, 16 registers of 4 bytes
  localparam logic [ADDR_W-1:0] PERIPH_BASE  = 32'h1A10_0000;
  localparam int unsigned       PERIPH_BYTES = 64;

  // read-only contents of peripheral register 0
  localparam logic [31:0] SOC_ID = 32'h50C0_0A01;

  // where a host request is steered
  typedef enum logic [1:0] {
    TGT_L2     = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_ERR    = 2'd2
  } tgt_e;

endpackage

/* verilog/stream_fifo.sv */
/*
 * stream_fifo
 * Circular buffer FIFO with valid/ready on both sides and a generic payload.
 */
module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  // full and empty come straight from the fill counter
  assign push_ready_o = (count_q != (PTR_W+1)'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule
